//--- cache_bank.f
common/cache_pkg.sv
logic/stream_fifo.sv
bank/bank_tags.sv
bank/bank_data.sv
bank/miss_entry.sv
bank/cache_bank.sv
tests/mem_responder.sv
tests/cache_bank_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= cache_bank.f
RTL_TOP   ?= cache_bank
TB_TOP    ?= cache_bank_tb
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/cache_bank_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench of the cache bank.
// Inputs change on the falling edge. Handshakes are sampled 1 ns later
// and hold until the next rising edge.
// The reference memory starts from the same $random sequence as the
// memory model and follows every core write.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cache_bank_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    localparam int         MEM_WORDS       = 1024;
    localparam int         SEED            = 32'h2bb48dfe;
    localparam int         NUM_TESTS       = 6;
    localparam int         CYCLES_PER_TEST = 200;
    localparam word_addr_t ADDR_A          = 16'h0123;
    localparam word_addr_t ADDR_B          = 16'h0236;

    logic      clk, reset, rsp_hold;
    logic      core_req_valid, core_req_ready, core_rsp_valid, core_rsp_ready;
    logic      mem_req_valid, mem_req_ready, mem_rsp_valid, mem_rsp_ready;
    core_req_t core_req;
    core_rsp_t core_rsp;
    mem_req_t  mem_req;
    line_t     mem_rsp_data;
    int        seed;
    word_t     ref_mem [MEM_WORDS];
    core_rsp_t got_rsp [$];
    mem_req_t  got_mreq [$];

    cache_bank #(.NUM_LINES(16), .RSP_DEPTH(4), .MREQ_DEPTH(8)) dut_i (.*);

    mem_responder #(.MEM_WORDS(MEM_WORDS), .LATENCY(5), .SEED(SEED)) mem_i (.*);

    always #4 clk = ~clk;

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rsp(input string name, input core_rsp_t exp, input core_rsp_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s: expected data %h tag %h, actual data %h tag %h",
                               name, exp.data, exp.tag, act.data, act.tag));
        end
    endtask

    // data bytes only count where the line byte enable is set
    task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
        logic ok;
        ok = (act.rw === exp.rw) && (act.addr === exp.addr);
        if (exp.rw) begin
            ok = ok && (act.byteen === exp.byteen);
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (exp.byteen[b] && act.data[b*8 +: 8] !== exp.data[b*8 +: 8]) begin
                    ok = 1'b0;
                end
            end
        end
        if (!ok) begin
            stop_run($sformatf("ERROR %s: expected rw %b addr %h be %h data %h, %s %b %h %h %h",
                               name, exp.rw, exp.addr, exp.byteen, exp.data, "actual",
                               act.rw, act.addr, act.byteen, act.data));
        end
    endtask

    task automatic send_req(input core_req_t req);
        @(negedge clk);
        core_req       = req;
        core_req_valid = 1'b1;
        #1;
        while (!core_req_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    task automatic wait_rsp(input int count);
        while (got_rsp.size() < count) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_mreq(input int count);
        while (got_mreq.size() < count) begin
            @(negedge clk);
        end
    endtask

    task automatic read_word(input string name, input word_addr_t addr,
                             input logic [REQ_TAG_WIDTH-1:0] tag);
        core_req_t req;
        core_rsp_t exp;
        int        base;
        req  = '{rw: 1'b0, addr: addr, byteen: '1, data: '0, tag: tag};
        exp  = '{data: ref_mem[int'(addr) % MEM_WORDS], tag: tag};
        base = got_rsp.size();
        send_req(req);
        wait_rsp(base + 1);
        check_rsp(name, exp, got_rsp[base]);
    endtask

    // updates the reference memory and returns the expected memory write
    task automatic write_word(input word_addr_t addr, input word_byteen_t be, input word_t data,
                              input logic [REQ_TAG_WIDTH-1:0] tag, output mem_req_t exp);
        core_req_t req;
        int        ws;
        req    = '{rw: 1'b1, addr: addr, byteen: be, data: data, tag: tag};
        ws     = int'(addr) % LINE_WORDS;
        exp    = '0;
        exp.rw = 1'b1;
        exp.addr = addr[ADDR_WIDTH-1:WORD_SEL_BITS];
        exp.byteen[ws*WORD_BYTES +: WORD_BYTES] = be;
        exp.data[ws*WORD_WIDTH +: WORD_WIDTH]   = data;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                ref_mem[int'(addr) % MEM_WORDS][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        send_req(req);
    endtask

    task automatic test_reset();
        @(negedge clk);
        if (core_rsp_valid || mem_req_valid) begin
            stop_run("core_rsp_valid or mem_req_valid is high after reset");
        end
    endtask

    task automatic test_read_miss();
        mem_req_t exp;
        int       base;
        base = got_mreq.size();
        read_word("read_miss", ADDR_A, 8'h11);
        if (got_mreq.size() != base + 1) begin
            stop_run("read miss did not send exactly one memory request");
        end
        exp      = '0;
        exp.addr = ADDR_A[ADDR_WIDTH-1:WORD_SEL_BITS];
        check_mem_req("read_miss", exp, got_mreq[base]);
    endtask

    // another word of the line that the read miss brought in
    task automatic test_read_hit();
        int base;
        base = got_mreq.size();
        read_word("read_hit", ADDR_A - 16'd1, 8'h12);
        if (got_mreq.size() != base) begin
            stop_run("read hit sent a memory request");
        end
    endtask

    task automatic test_write_hit();
        mem_req_t exp;
        int       base;
        base = got_mreq.size();
        write_word(ADDR_A, 4'b0110, 32'hdead_beef, 8'h21, exp);
        wait_mreq(base + 1);
        check_mem_req("write_hit", exp, got_mreq[base]);
        read_word("write_hit", ADDR_A, 8'h22);
    endtask

    task automatic test_write_miss();
        mem_req_t exp;
        int       base, rsp_base;
        base     = got_mreq.size();
        rsp_base = got_rsp.size();
        write_word(ADDR_B, 4'b1001, 32'h5a5a_c3c3, 8'h31, exp);
        wait_mreq(base + 1);
        check_mem_req("write_miss", exp, got_mreq[base]);
        repeat (4) @(negedge clk);
        if (got_rsp.size() != rsp_base) begin
            stop_run("a core write produced a core response");
        end
        read_word("write_miss", ADDR_B, 8'h32);
    endtask

    task automatic test_back_pressure();
        core_rsp_t  exp_q [$];
        core_req_t  req;
        mem_req_t   unused_mreq;
        word_addr_t addr;
        logic [7:0] tag;
        int         base;
        base = got_rsp.size();
        @(negedge clk);
        rsp_hold = 1'b1;
        fork
            begin
                // every third op is a write
                // addresses span lines 0x48 to 0x4d
                for (int i = 0; i < 12; i++) begin
                    addr = 16'h0120 + word_addr_t'((i * 5) % 24);
                    tag  = 8'h60 + 8'(i);
                    if (i % 3 == 1) begin
                        write_word(addr, 4'(4'hf >> (i % 4)), 32'hc0de_0000 + i, tag, unused_mreq);
                    end else begin
                        exp_q.push_back(core_rsp_t'{data: ref_mem[int'(addr) % MEM_WORDS],
                                                    tag: tag});
                        req = '{rw: 1'b0, addr: addr, byteen: '1, data: '0, tag: tag};
                        send_req(req);
                    end
                end
            end
            begin
                repeat (60) @(negedge clk);
                rsp_hold = 1'b0;
            end
        join
        wait_rsp(base + exp_q.size());
        for (int k = 0; k < exp_q.size(); k++) begin
            check_rsp("back_pressure", exp_q[k], got_rsp[base + k]);
        end
    endtask

    // monitor of responses and memory requests and the replay hit check
    initial begin
        core_rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            core_rsp_ready = !rsp_hold;
            #1;
            if (!reset && core_rsp_valid && core_rsp_ready) begin
                got_rsp.push_back(core_rsp);
            end
            if (!reset && mem_req_valid && mem_req_ready) begin
                got_mreq.push_back(mem_req);
            end
            if (!reset && dut_i.valid_st1 && !dut_i.st1.is_fill && !dut_i.st1.is_creq
                    && !dut_i.hit_st1) begin
                stop_run("a replayed read missed the cache in stage 1");
            end
        end
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        stop_run("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        rsp_hold       = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        seed           = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = $random(seed);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset();
        test_read_miss();
        test_read_hit();
        test_write_hit();
        test_write_miss();
        test_back_pressure();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- tests/mem_responder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench memory model for the bank's memory port.
// Only one line read is served at a time, LATENCY cycles after it is
// taken. Writes merge their line byte enables at once.
// Word addresses wrap at MEM_WORDS. Contents come from $random(SEED).
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_responder #(
    parameter int MEM_WORDS = 1024,
    parameter int LATENCY   = 5,
    parameter int SEED      = 0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_req_valid,
    input  cache_pkg::mem_req_t mem_req,
    output logic                mem_req_ready,
    output logic                mem_rsp_valid,
    output cache_pkg::line_t    mem_rsp_data,
    input  logic                mem_rsp_ready
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    word_t      mem [MEM_WORDS];
    int         seed;
    int         delay;
    logic       pending, req_fire, rsp_fire;
    mem_req_t   req_q;
    line_addr_t rd_addr;

    function automatic int word_index(input line_addr_t line, input int w);
        return (int'(line) * LINE_WORDS + w) % MEM_WORDS;
    endfunction

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        pending       = 1'b0;
        req_fire      = 1'b0;
        rsp_fire      = 1'b0;
        delay         = 0;
        seed          = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
        end
        forever begin
            @(negedge clk);
            // act on the transfers of the last rising edge
            if (rsp_fire) begin
                pending       = 1'b0;
                mem_rsp_valid = 1'b0;
            end
            if (req_fire && req_q.rw) begin
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (req_q.byteen[b]) begin
                        mem[word_index(req_q.addr, b / WORD_BYTES)][(b % WORD_BYTES)*8 +: 8] =
                            req_q.data[b*8 +: 8];
                    end
                end
            end else if (req_fire) begin
                pending = 1'b1;
                delay   = LATENCY;
                rd_addr = req_q.addr;
            end else if (pending && !mem_rsp_valid) begin
                delay--;
                if (delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    for (int w = 0; w < LINE_WORDS; w++) begin
                        mem_rsp_data[w*WORD_WIDTH +: WORD_WIDTH] = mem[word_index(rd_addr, w)];
                    end
                end
            end
            mem_req_ready = !pending && !reset;
            // handshake values now hold until the next rising edge
            #1;
            req_fire = mem_req_valid && mem_req_ready;
            req_q    = mem_req;
            rsp_fire = mem_rsp_valid && mem_rsp_ready;
        end
    end

endmodule

//--- bank/cache_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped write-through cache bank with no write-allocate.
// Only one read miss can be outstanding. The core is held off while it
// is pending, so a memory response always answers that single miss.
// NUM_LINES must be a power of two and at least 2.
// MREQ_DEPTH must be at least 4 for the almost-full hold-off to work.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cache_bank #(
    parameter int NUM_LINES  = 16,
    parameter int RSP_DEPTH  = 4,
    parameter int MREQ_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 core_req_valid,
    input  cache_pkg::core_req_t core_req,
    output logic                 core_req_ready,
    output logic                 core_rsp_valid,
    output cache_pkg::core_rsp_t core_rsp,
    input  logic                 core_rsp_ready,
    output logic                 mem_req_valid,
    output cache_pkg::mem_req_t  mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  cache_pkg::line_t     mem_rsp_data,
    output logic                 mem_rsp_ready
);
    import cache_pkg::*;

    // replay when neither flag is set
    typedef struct packed {
        logic      is_fill;
        logic      is_creq;
        core_req_t req;
        line_t     fill_data;
    } stage_t;

    stage_t     stage_in, st0, st1;
    logic       valid_in, valid_st0, valid_st1, hit_st1, pipe_stall;
    logic       replay_valid, replay_ready, miss_busy, fill_fire, allocate;
    logic       mem_rd_valid, mem_rd_taken, rsp_full, rsp_empty;
    logic       mreq_push, mreq_full, mreq_alm_full, mreq_empty;
    logic       creq_rd_st0, rd_st1, wr_st1, rsp_push_st1;
    core_req_t  replay_req;
    line_addr_t mem_rd_addr, fill_addr;
    word_t      read_data_st1;
    core_rsp_t  rsp_in;
    mem_req_t   mreq_in;

    // replay first, then fill, then core
    assign replay_ready   = ~pipe_stall;
    assign mem_rsp_ready  = ~replay_valid && ~pipe_stall;
    assign creq_rd_st0    = valid_st0 && st0.is_creq && ~st0.req.rw;
    assign core_req_ready = ~replay_valid && ~mem_rsp_valid && ~pipe_stall && ~miss_busy
                         && ~creq_rd_st0 && ~(rd_st1 && st1.is_creq) && ~mreq_alm_full;
    assign fill_fire      = mem_rsp_valid && mem_rsp_ready;
    assign valid_in       = (replay_valid && replay_ready) || fill_fire
                         || (core_req_valid && core_req_ready);

    always_comb begin
        stage_in.is_fill   = ~replay_valid && mem_rsp_valid;
        stage_in.is_creq   = ~replay_valid && ~mem_rsp_valid;
        stage_in.req       = replay_valid ? replay_req : core_req;
        stage_in.fill_data = mem_rsp_data;
        if (stage_in.is_fill) begin
            stage_in.req.rw   = 1'b0;
            stage_in.req.addr = {fill_addr, {WORD_SEL_BITS{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_st0 <= 1'b0;
            valid_st1 <= 1'b0;
        end else if (~pipe_stall) begin
            valid_st0 <= valid_in;
            valid_st1 <= valid_st0;
        end
    end

    always_ff @(posedge clk) begin
        if (~pipe_stall) begin
            st0 <= stage_in;
            st1 <= st0;
        end
    end

    bank_tags #(.NUM_LINES(NUM_LINES)) tags_i (
        .clk       (clk),
        .reset     (reset),
        .stall     (pipe_stall),
        .lookup    (valid_st0 && ~st0.is_fill),
        .fill      (valid_st0 && st0.is_fill),
        .line_addr (st0.req.addr[ADDR_WIDTH-1:WORD_SEL_BITS]),
        .hit       (hit_st1)
    );

    // stage 1 decisions, replays always hit
    assign rd_st1       = valid_st1 && ~st1.is_fill && ~st1.req.rw;
    assign wr_st1       = valid_st1 && st1.is_creq && st1.req.rw;
    assign rsp_push_st1 = rd_st1 && hit_st1;
    assign allocate     = rd_st1 && st1.is_creq && ~hit_st1 && ~pipe_stall;
    // the miss line read takes the queue port from a stage-1 write
    assign pipe_stall   = (rsp_push_st1 && rsp_full) || (wr_st1 && mem_rd_valid);

    bank_data #(.NUM_LINES(NUM_LINES)) data_i (
        .clk        (clk),
        .stall      (pipe_stall),
        .line_addr  (st1.req.addr[ADDR_WIDTH-1:WORD_SEL_BITS]),
        .word_sel   (st1.req.addr[WORD_SEL_BITS-1:0]),
        .write      (wr_st1 && hit_st1),
        .byteen     (st1.req.byteen),
        .write_data (st1.req.data),
        .fill       (valid_st1 && st1.is_fill),
        .fill_data  (st1.fill_data),
        .read_data  (read_data_st1)
    );

    miss_entry miss_i (
        .clk          (clk),
        .reset        (reset),
        .allocate     (allocate),
        .alloc_req    (st1.req),
        .busy         (miss_busy),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_taken (mem_rd_taken),
        .fill_fire    (fill_fire),
        .fill_addr    (fill_addr),
        .replay_valid (replay_valid),
        .replay_req   (replay_req),
        .replay_ready (replay_ready)
    );

    assign rsp_in = '{data: read_data_st1, tag: st1.req.tag};

    stream_fifo #(.payload_t(core_rsp_t), .DEPTH(RSP_DEPTH)) rsp_queue_i (
        .clk       (clk),
        .reset     (reset),
        .push      (rsp_push_st1 && ~pipe_stall),
        .push_data (rsp_in),
        .pop       (core_rsp_valid && core_rsp_ready),
        .pop_data  (core_rsp),
        .empty     (rsp_empty),
        .full      (rsp_full),
        .alm_full  ()
    );

    assign core_rsp_valid = ~rsp_empty;

    // write-through word goes out replicated with its byte lanes enabled
    always_comb begin
        mreq_in.rw     = ~mem_rd_valid;
        mreq_in.addr   = mem_rd_valid ? mem_rd_addr : st1.req.addr[ADDR_WIDTH-1:WORD_SEL_BITS];
        mreq_in.data   = {LINE_WORDS{st1.req.data}};
        mreq_in.byteen = '1;
        if (~mem_rd_valid) begin
            mreq_in.byteen = '0;
            mreq_in.byteen[st1.req.addr[WORD_SEL_BITS-1:0]*WORD_BYTES +: WORD_BYTES] =
                st1.req.byteen;
        end
    end

    assign mem_rd_taken = mem_rd_valid && ~mreq_full;
    assign mreq_push    = mem_rd_taken || (wr_st1 && ~pipe_stall);

    stream_fifo #(.payload_t(mem_req_t), .DEPTH(MREQ_DEPTH)) mreq_queue_i (
        .clk       (clk),
        .reset     (reset),
        .push      (mreq_push),
        .push_data (mreq_in),
        .pop       (mem_req_valid && mem_req_ready),
        .pop_data  (mem_req),
        .empty     (mreq_empty),
        .full      (mreq_full),
        .alm_full  (mreq_alm_full)
    );

    assign mem_req_valid = ~mreq_empty;

endmodule

//--- bank/miss_entry.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single outstanding read miss.
// Allocation is only honoured while idle. The bank keeps new core
// requests out while busy is high. A fill seen outside the wait state
// is ignored here.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module miss_entry (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  allocate,
    input  cache_pkg::core_req_t  alloc_req,
    output logic                  busy,
    output logic                  mem_rd_valid,
    output cache_pkg::line_addr_t mem_rd_addr,
    input  logic                  mem_rd_taken,
    input  logic                  fill_fire,
    output cache_pkg::line_addr_t fill_addr,
    output logic                  replay_valid,
    output cache_pkg::core_req_t  replay_req,
    input  logic                  replay_ready
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_send,
        st_wait,
        st_replay
    } state_t;

    state_t    state;
    core_req_t req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   if (allocate) state <= st_send;
                st_send:   if (mem_rd_taken) state <= st_wait;
                st_wait:   if (fill_fire) state <= st_replay;
                st_replay: if (replay_ready) state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (allocate && state == st_idle) begin
            req_q <= alloc_req;
        end
    end

    assign busy         = (state != st_idle);
    assign mem_rd_valid = (state == st_send);
    assign mem_rd_addr  = req_q.addr[ADDR_WIDTH-1:WORD_SEL_BITS];
    assign fill_addr    = req_q.addr[ADDR_WIDTH-1:WORD_SEL_BITS];
    // replayed read goes back through the pipeline as a hit
    assign replay_valid = (state == st_replay);
    assign replay_req   = req_q;

endmodule

//--- bank/bank_data.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line data store of the bank, used in stage 1.
// Writes are synchronous and the read is combinational, so a read in
// the cycle after a write already sees the new bytes.
// A fill takes precedence over a write hit to the same cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module bank_data #(
    parameter int NUM_LINES = 16
) (
    input  logic                                clk,
    input  logic                                stall,
    input  cache_pkg::line_addr_t               line_addr,
    input  logic [cache_pkg::WORD_SEL_BITS-1:0] word_sel,
    input  logic                                write,
    input  cache_pkg::word_byteen_t             byteen,
    input  cache_pkg::word_t                    write_data,
    input  logic                                fill,
    input  cache_pkg::line_t                    fill_data,
    output cache_pkg::word_t                    read_data
);
    import cache_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_LINES);

    line_t               lines [NUM_LINES];
    line_t               merged;
    logic [IDX_BITS-1:0] idx;

    assign idx = line_addr[IDX_BITS-1:0];

    assign read_data = lines[idx][word_sel*WORD_WIDTH +: WORD_WIDTH];

    // current line with the enabled bytes of the selected word replaced
    always_comb begin
        merged = lines[idx];
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (byteen[b]) begin
                merged[word_sel*WORD_WIDTH + b*8 +: 8] = write_data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (~stall) begin
            if (fill) begin
                lines[idx] <= fill_data;
            end else if (write) begin
                lines[idx] <= merged;
            end
        end
    end

endmodule

//--- bank/bank_tags.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag and valid store of the direct-mapped bank.
// Lookup and fill both act in stage 0. The hit flag is registered, so
// it lines up with the request in stage 1.
// NUM_LINES must be a power of two and at least 2.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module bank_tags #(
    parameter int NUM_LINES = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  lookup,
    input  logic                  fill,
    input  cache_pkg::line_addr_t line_addr,
    output logic                  hit
);
    import cache_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS = LINE_ADDR_WIDTH - IDX_BITS;

    logic [NUM_LINES-1:0] valid_q;
    logic [TAG_BITS-1:0]  tag_mem [NUM_LINES];
    logic [IDX_BITS-1:0]  idx;
    logic [TAG_BITS-1:0]  tag;

    assign idx = line_addr[IDX_BITS-1:0];
    assign tag = line_addr[LINE_ADDR_WIDTH-1:IDX_BITS];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            hit     <= 1'b0;
        end else if (~stall) begin
            if (fill) begin
                valid_q[idx] <= 1'b1;
            end
            hit <= lookup && valid_q[idx] && (tag_mem[idx] == tag);
        end
    end

    // stored tags only matter once their valid bit is set
    always_ff @(posedge clk) begin
        if (~stall && fill) begin
            tag_mem[idx] <= tag;
        end
    end

endmodule

//--- logic/stream_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO with a payload given by type parameter.
// A push into a full FIFO or a pop from an empty one is ignored, so
// the user checks full and empty first.
// pop_data shows the head entry while empty is low.
// alm_full is high with two or fewer free slots.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full,
    output logic     alm_full
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t            slots [DEPTH];
    logic [PTR_BITS-1:0] rd_ptr, wr_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_push, do_pop;

    assign do_push = push && ~full;
    assign do_pop  = pop && ~empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && ~do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && ~do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    assign pop_data = slots[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_BITS'(DEPTH));
    assign alm_full = (int'(count) + 2 >= DEPTH);

endmodule

//--- common/cache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths and payload types of the cache bank.
// A core address is a word address. The low WORD_SEL_BITS select a
// word of the four-word line and the upper bits form the line address.
// The memory side always moves whole lines with line byte enables.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cache_pkg;

    localparam int WORD_WIDTH    = 32;
    localparam int WORD_BYTES    = WORD_WIDTH / 8;
    localparam int LINE_WORDS    = 4;
    localparam int ADDR_WIDTH    = 16;
    localparam int REQ_TAG_WIDTH = 8;

    // derived sizes
    localparam int WORD_SEL_BITS   = $clog2(LINE_WORDS);
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - WORD_SEL_BITS;
    localparam int LINE_WIDTH      = WORD_WIDTH * LINE_WORDS;
    localparam int LINE_BYTES      = WORD_BYTES * LINE_WORDS;

    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [WORD_BYTES-1:0]      word_byteen_t;
    typedef logic [LINE_WIDTH-1:0]      line_t;
    typedef logic [LINE_BYTES-1:0]      line_byteen_t;
    typedef logic [ADDR_WIDTH-1:0]      word_addr_t;
    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;

    typedef struct packed {
        logic                     rw;
        word_addr_t               addr;
        word_byteen_t             byteen;
        word_t                    data;
        logic [REQ_TAG_WIDTH-1:0] tag;
    } core_req_t;

    typedef struct packed {
        word_t                    data;
        logic [REQ_TAG_WIDTH-1:0] tag;
    } core_rsp_t;

    // rw low is a line read, byteen and data then carry nothing
    typedef struct packed {
        logic         rw;
        line_addr_t   addr;
        line_byteen_t byteen;
        line_t        data;
    } mem_req_t;

endpackage
